//--- hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Word and PC width of the RV32 core.
`define RV_XLEN 32

// Width of the op sequence number and of the commit counter.
`define RV_OPID_WIDTH 16

// Width of an architectural register address.
`define RV_REG_ADDR_WIDTH 5

`endif

//--- hdl/RvTypes.sv
`include "rv_macros.svh"

package RvTypes;

    // R-type view of an instruction word.
    typedef struct packed {
        logic [6:0] funct7;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs2;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0] funct3;
        logic [`RV_REG_ADDR_WIDTH-1:0] rd;
        logic [6:0] opcode;
    } InsnRType;

    // I-type view of an instruction word.
    typedef struct packed {
        logic [11:0] imm12;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0] funct3;
        logic [`RV_REG_ADDR_WIDTH-1:0] rd;
        logic [6:0] opcode;
    } InsnIType;

    typedef union packed {
        InsnRType r;
        InsnIType i;
    } Insn;

    typedef enum logic [3:0] {
        Alu, AluImm, Load, Store, Branch, Jal, Jalr, Lui, Auipc, System, Unknown
    } OpClass;

    typedef enum logic [3:0] {
        InsnMisaligned = 4'd0,
        IllegalInsn = 4'd2
    } ExceptionCode;

    typedef struct packed {
        logic valid;
        ExceptionCode cause;
        logic [`RV_XLEN-1:0] value;
    } TrapInfo;

    typedef struct packed {
        OpClass opClass;
        logic [2:0] funct3;
        logic [`RV_XLEN-1:0] imm;
        logic writesRd;
        logic usesRs1;
        logic usesRs2;
    } Op;

    // Maps an instruction word onto its op class and immediate.
    function automatic Op Decode(input logic [`RV_XLEN-1:0] word);
        Insn insn;
        Op op;
        logic [`RV_XLEN-1:0] immI;
        logic [`RV_XLEN-1:0] immS;
        logic [`RV_XLEN-1:0] immB;
        logic [`RV_XLEN-1:0] immU;
        logic [`RV_XLEN-1:0] immJ;
        insn = word;
        immI = {{20{insn.i.imm12[11]}}, insn.i.imm12};
        // S, B, U and J immediates are scattered over the R-type fields.
        immS = {{20{insn.r.funct7[6]}}, insn.r.funct7, insn.r.rd};
        immB = {{20{insn.r.funct7[6]}}, insn.r.rd[0], insn.r.funct7[5:0],
                insn.r.rd[4:1], 1'b0};
        immU = {insn.r.funct7, insn.r.rs2, insn.r.rs1, insn.r.funct3, 12'b0};
        immJ = {{12{insn.r.funct7[6]}}, insn.r.rs1, insn.r.funct3, insn.r.rs2[0],
                insn.r.funct7[5:0], insn.r.rs2[4:1], 1'b0};

        op = '0;
        op.opClass = Unknown;
        op.funct3 = insn.r.funct3;
        case (insn.r.opcode)
            7'b0110011: begin
                if (insn.r.funct7 == 7'b0000000 || insn.r.funct7 == 7'b0100000) begin
                    op.opClass = Alu;
                    op.writesRd = 1'b1;
                    op.usesRs1 = 1'b1;
                    op.usesRs2 = 1'b1;
                end
            end
            7'b0010011: begin
                op.opClass = AluImm;
                op.imm = immI;
                op.writesRd = 1'b1;
                op.usesRs1 = 1'b1;
            end
            7'b0000011: begin
                op.opClass = Load;
                op.imm = immI;
                op.writesRd = 1'b1;
                op.usesRs1 = 1'b1;
            end
            7'b0100011: begin
                op.opClass = Store;
                op.imm = immS;
                op.usesRs1 = 1'b1;
                op.usesRs2 = 1'b1;
            end
            7'b1100011: begin
                // funct3 010 and 011 are reserved branch encodings.
                if (insn.r.funct3 != 3'b010 && insn.r.funct3 != 3'b011) begin
                    op.opClass = Branch;
                    op.imm = immB;
                    op.usesRs1 = 1'b1;
                    op.usesRs2 = 1'b1;
                end
            end
            7'b1101111: begin
                op.opClass = Jal;
                op.imm = immJ;
                op.writesRd = 1'b1;
            end
            7'b1100111: begin
                if (insn.r.funct3 == 3'b000) begin
                    op.opClass = Jalr;
                    op.imm = immI;
                    op.writesRd = 1'b1;
                    op.usesRs1 = 1'b1;
                end
            end
            7'b0110111: begin
                op.opClass = Lui;
                op.imm = immU;
                op.writesRd = 1'b1;
            end
            7'b0010111: begin
                op.opClass = Auipc;
                op.imm = immU;
                op.writesRd = 1'b1;
            end
            7'b1110011: begin
                op.opClass = System;
                op.imm = immI;
                op.writesRd = 1'b1;
                op.usesRs1 = 1'b1;
            end
            default: begin
                op.opClass = Unknown;
            end
        endcase
        return op;
    endfunction

endpackage

//--- hdl/StageIF.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

// Fetch register contents as seen by decode.
interface FetchStageIF;
    logic valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    RvTypes::TrapInfo trapInfo;

    modport ThisStage(
        output valid, pc, insn, trapInfo
    );

    modport NextStage(
        input valid, pc, insn, trapInfo
    );
endinterface

// Decode register contents, handed to the consumer.
interface DecodeStageIF;
    logic valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] insn;
    RvTypes::Op op;
    logic [`RV_OPID_WIDTH-1:0] opId;
    logic [`RV_REG_ADDR_WIDTH-1:0] srcRegAddr1;
    logic [`RV_REG_ADDR_WIDTH-1:0] srcRegAddr2;
    logic [`RV_REG_ADDR_WIDTH-1:0] dstRegAddr;
    RvTypes::TrapInfo trapInfo;

    modport ThisStage(
        output valid, pc, insn, op, opId, srcRegAddr1, srcRegAddr2, dstRegAddr, trapInfo
    );

    modport Output(
        input valid, pc, insn, op, opId, srcRegAddr1, srcRegAddr2, dstRegAddr, trapInfo
    );
endinterface

// Stall and flush control, plus the count of ops taken by the consumer.
interface PipelineControllerIF;
    logic ifStall;
    logic idStall;
    logic flush;
    logic [`RV_OPID_WIDTH-1:0] opCommitCount;

    modport Controller(
        output ifStall, idStall, flush, opCommitCount
    );

    modport FetchStage(
        input ifStall, flush
    );

    modport DecodeStage(
        input idStall, flush, opCommitCount
    );
endinterface

//--- hdl/FetchStage.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module FetchStage(
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic [`RV_XLEN-1:0] inPc,
    input logic [`RV_XLEN-1:0] inInsn,
    FetchStageIF.ThisStage nextStage,
    PipelineControllerIF.FetchStage ctrl
);
    RvTypes::TrapInfo trapInfo;

    // A PC that is not word aligned traps right here.
    always_comb begin
        trapInfo = '0;
        if (inPc[1:0] != 2'b00) begin
            trapInfo.valid = 1'b1;
            trapInfo.cause = RvTypes::InsnMisaligned;
            trapInfo.value = inPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ctrl.flush) begin
            nextStage.valid <= 1'b0;
            nextStage.trapInfo <= '0;
        end
        else if (ctrl.ifStall) begin
            // Hold.
        end
        else if (inValid) begin
            // inReady is high here, so the word is taken.
            nextStage.valid <= 1'b1;
            nextStage.pc <= inPc;
            nextStage.insn <= inInsn;
            nextStage.trapInfo <= trapInfo;
        end
        else begin
            nextStage.valid <= 1'b0;
            nextStage.trapInfo <= '0;
        end
    end
endmodule

//--- hdl/DecodeStage.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module DecodeStage(
    input logic clk,
    input logic rst,
    FetchStageIF.NextStage prevStage,
    DecodeStageIF.ThisStage nextStage,
    PipelineControllerIF.DecodeStage ctrl
);
    RvTypes::Insn insn;
    RvTypes::Op op;
    RvTypes::TrapInfo trapInfo;
    logic [`RV_REG_ADDR_WIDTH-1:0] srcRegAddr1;
    logic [`RV_REG_ADDR_WIDTH-1:0] srcRegAddr2;
    logic [`RV_REG_ADDR_WIDTH-1:0] dstRegAddr;
    logic advance;

    // Sequence number for the next op entering the register.
    logic [`RV_OPID_WIDTH-1:0] opId;

    always_comb begin
        insn = prevStage.insn;
        op = RvTypes::Decode(prevStage.insn);
        srcRegAddr1 = insn.r.rs1;
        srcRegAddr2 = insn.r.rs2;
        dstRegAddr = insn.r.rd;

        // An earlier fetch trap wins over an illegal encoding.
        if (prevStage.valid && !prevStage.trapInfo.valid &&
            op.opClass == RvTypes::Unknown) begin
            trapInfo.valid = 1'b1;
            trapInfo.cause = RvTypes::IllegalInsn;
            trapInfo.value = prevStage.insn;
        end
        else begin
            trapInfo = prevStage.trapInfo;
        end

        advance = prevStage.valid && !ctrl.idStall;
    end

    always_ff @(posedge clk) begin
        if (rst || ctrl.flush) begin
            nextStage.valid <= 1'b0;
            nextStage.trapInfo <= '0;
        end
        else if (ctrl.idStall) begin
            // Hold until the consumer takes the op.
        end
        else if (!prevStage.valid) begin
            nextStage.valid <= 1'b0;
            nextStage.trapInfo <= '0;
        end
        else begin
            nextStage.valid <= 1'b1;
            nextStage.pc <= prevStage.pc;
            nextStage.insn <= prevStage.insn;
            nextStage.op <= op;
            nextStage.opId <= opId;
            nextStage.srcRegAddr1 <= srcRegAddr1;
            nextStage.srcRegAddr2 <= srcRegAddr2;
            nextStage.dstRegAddr <= dstRegAddr;
            nextStage.trapInfo <= trapInfo;
        end

        // Numbering restarts from what the consumer really took.
        if (rst) begin
            opId <= '0;
        end
        else if (ctrl.flush) begin
            opId <= ctrl.opCommitCount;
        end
        else if (advance) begin
            opId <= opId + 1'b1;
        end
    end
endmodule

//--- hdl/PipelineController.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module PipelineController(
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input logic decodeValid,
    input logic outReady,
    input logic flushReq,
    output logic inReady,
    PipelineControllerIF.Controller ctrl
);
    logic idStall;
    logic ifStall;
    logic handOff;
    logic [`RV_OPID_WIDTH-1:0] commitCount;

    always_comb begin
        handOff = decodeValid && outReady;
        idStall = decodeValid && !outReady;
        // Fetch only stalls when its register is full behind a stalled decode.
        ifStall = idStall && fetchValid;

        ctrl.idStall = idStall;
        ctrl.ifStall = ifStall;
        ctrl.flush = flushReq;
        // Includes this cycle's hand-off so a flush reloads the right opId.
        ctrl.opCommitCount = commitCount + {{(`RV_OPID_WIDTH-1){1'b0}}, handOff};
        inReady = !ifStall && !flushReq;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commitCount <= '0;
        end
        else begin
            commitCount <= ctrl.opCommitCount;
        end
    end
endmodule

//--- hdl/DecodeFrontEnd.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module DecodeFrontEnd(
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic [`RV_XLEN-1:0] inPc,
    input logic [`RV_XLEN-1:0] inInsn,
    input logic outReady,
    input logic flush,
    output logic inReady,
    output logic outValid,
    output logic [`RV_XLEN-1:0] outPc,
    output logic [`RV_XLEN-1:0] outInsn,
    output RvTypes::OpClass outOpClass,
    output logic [`RV_XLEN-1:0] outImm,
    output logic outWritesRd,
    output logic [`RV_REG_ADDR_WIDTH-1:0] outRs1,
    output logic [`RV_REG_ADDR_WIDTH-1:0] outRs2,
    output logic [`RV_REG_ADDR_WIDTH-1:0] outRd,
    output logic [`RV_OPID_WIDTH-1:0] outOpId,
    output logic outTrapValid,
    output RvTypes::ExceptionCode outTrapCause,
    output logic [`RV_XLEN-1:0] outTrapValue
);
    FetchStageIF fetchIf();
    DecodeStageIF decodeIf();
    PipelineControllerIF ctrlIf();

    FetchStage u_fetchStage(
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inPc(inPc),
        .inInsn(inInsn),
        .nextStage(fetchIf),
        .ctrl(ctrlIf)
    );

    DecodeStage u_decodeStage(
        .clk(clk),
        .rst(rst),
        .prevStage(fetchIf),
        .nextStage(decodeIf),
        .ctrl(ctrlIf)
    );

    PipelineController u_pipelineController(
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchIf.valid),
        .decodeValid(decodeIf.valid),
        .outReady(outReady),
        .flushReq(flush),
        .inReady(inReady),
        .ctrl(ctrlIf)
    );

    // The decode register is the output register.
    assign outValid = decodeIf.valid;
    assign outPc = decodeIf.pc;
    assign outInsn = decodeIf.insn;
    assign outOpClass = decodeIf.op.opClass;
    assign outImm = decodeIf.op.imm;
    assign outWritesRd = decodeIf.op.writesRd;
    assign outRs1 = decodeIf.srcRegAddr1;
    assign outRs2 = decodeIf.srcRegAddr2;
    assign outRd = decodeIf.dstRegAddr;
    assign outOpId = decodeIf.opId;
    assign outTrapValid = decodeIf.trapInfo.valid;
    assign outTrapCause = decodeIf.trapInfo.cause;
    assign outTrapValue = decodeIf.trapInfo.value;
endmodule

//--- dv/DecodeFrontEnd_assert.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module DecodeFrontEndAssert(
    input logic clk,
    input logic rst,
    input logic flush,
    input logic inValid,
    input logic inReady,
    input logic [`RV_XLEN-1:0] inPc,
    input logic [`RV_XLEN-1:0] inInsn,
    input logic outValid,
    input logic outReady,
    input logic [`RV_XLEN-1:0] outPc,
    input logic [`RV_XLEN-1:0] outInsn,
    input logic [`RV_OPID_WIDTH-1:0] outOpId,
    input logic outTrapValid
);
    // Reset empties the output register.
    resetClearsOutput: assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid high in the cycle after reset");

    // A stalled op stays put until the consumer takes it.
    outputHolds: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady && !flush |=> outValid && $stable(outPc) &&
        $stable(outInsn) && $stable(outOpId) && $stable(outTrapValid))
        else $error("output changed while stalled");

    // The producer keeps an offered word until it is taken.
    inputHolds: assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady && !flush |=> inValid && $stable(inPc) && $stable(inInsn))
        else $error("input changed before it was taken");

    trapNeedsValid: assert property (@(posedge clk) disable iff (rst)
        outTrapValid |-> outValid)
        else $error("trap reported without a valid op");
endmodule

bind DecodeFrontEnd DecodeFrontEndAssert u_assert(
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .inValid(inValid),
    .inReady(inReady),
    .inPc(inPc),
    .inInsn(inInsn),
    .outValid(outValid),
    .outReady(outReady),
    .outPc(outPc),
    .outInsn(outInsn),
    .outOpId(outOpId),
    .outTrapValid(outTrapValid)
);

//--- dv/tb_DecodeFrontEnd.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module tb_DecodeFrontEnd;
    localparam int txnTarget = 2000;
    localparam int cycleLimit = 4 * txnTarget + 100;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] insn;
        RvTypes::OpClass opClass;
        logic [`RV_XLEN-1:0] imm;
        logic writesRd;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs1;
        logic [`RV_REG_ADDR_WIDTH-1:0] rs2;
        logic [`RV_REG_ADDR_WIDTH-1:0] rd;
        RvTypes::TrapInfo trap;
    } ExpectedOp;

    logic clk;
    logic rst;
    logic inValid;
    logic [`RV_XLEN-1:0] inPc;
    logic [`RV_XLEN-1:0] inInsn;
    logic outReady;
    logic flush;
    logic inReady;
    logic outValid;
    logic [`RV_XLEN-1:0] outPc;
    logic [`RV_XLEN-1:0] outInsn;
    RvTypes::OpClass outOpClass;
    logic [`RV_XLEN-1:0] outImm;
    logic outWritesRd;
    logic [`RV_REG_ADDR_WIDTH-1:0] outRs1;
    logic [`RV_REG_ADDR_WIDTH-1:0] outRs2;
    logic [`RV_REG_ADDR_WIDTH-1:0] outRd;
    logic [`RV_OPID_WIDTH-1:0] outOpId;
    logic outTrapValid;
    RvTypes::ExceptionCode outTrapCause;
    logic [`RV_XLEN-1:0] outTrapValue;

    logic [31:0] lfsrState;
    logic inHeld;
    int takenCount;
    int cycleCount;
    // Ops handed off so far, which is also the next expected opId.
    logic [`RV_OPID_WIDTH-1:0] handoffCount;
    ExpectedOp expectedOps[$];

    DecodeFrontEnd u_dut(
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inPc(inPc),
        .inInsn(inInsn),
        .outReady(outReady),
        .flush(flush),
        .inReady(inReady),
        .outValid(outValid),
        .outPc(outPc),
        .outInsn(outInsn),
        .outOpClass(outOpClass),
        .outImm(outImm),
        .outWritesRd(outWritesRd),
        .outRs1(outRs1),
        .outRs2(outRs2),
        .outRd(outRd),
        .outOpId(outOpId),
        .outTrapValid(outTrapValid),
        .outTrapCause(outTrapCause),
        .outTrapValue(outTrapValue)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return bits;
    endfunction

    function automatic logic [6:0] listOpcode(input logic [31:0] index);
        case (index)
            0: return 7'b0110011;
            1: return 7'b0010011;
            2: return 7'b0000011;
            3: return 7'b0100011;
            4: return 7'b1100011;
            5: return 7'b1101111;
            6: return 7'b1100111;
            7: return 7'b0110111;
            8: return 7'b0010111;
            default: return 7'b1110011;
        endcase
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] sel;
        logic [31:0] word;
        sel = takeBits(4);
        word = takeBits(32);
        // One draw in sixteen keeps a fully random opcode.
        if (sel != 15) begin
            word[6:0] = listOpcode(sel % 10);
        end
        if (takeBits(2) != 0) begin
            if (word[6:0] == 7'b0110011) begin
                word[31:25] = {1'b0, word[30], 5'b00000};
            end
            if (word[6:0] == 7'b1100111) begin
                word[14:12] = 3'b000;
            end
        end
        return word;
    endfunction

    function automatic ExpectedOp modelDecode(input logic [31:0] pc, input logic [31:0] w);
        ExpectedOp e;
        e = '0;
        e.pc = pc;
        e.insn = w;
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.rd = w[11:7];
        case (w[6:0])
            7'b0110011: e.opClass = RvTypes::Alu;
            7'b0010011: e.opClass = RvTypes::AluImm;
            7'b0000011: e.opClass = RvTypes::Load;
            7'b0100011: e.opClass = RvTypes::Store;
            7'b1100011: e.opClass = RvTypes::Branch;
            7'b1101111: e.opClass = RvTypes::Jal;
            7'b1100111: e.opClass = RvTypes::Jalr;
            7'b0110111: e.opClass = RvTypes::Lui;
            7'b0010111: e.opClass = RvTypes::Auipc;
            7'b1110011: e.opClass = RvTypes::System;
            default: e.opClass = RvTypes::Unknown;
        endcase
        if ((e.opClass == RvTypes::Alu && w[31:25] != 7'b0000000 && w[31:25] != 7'b0100000) ||
            (e.opClass == RvTypes::Jalr && w[14:12] != 3'b000) ||
            (e.opClass == RvTypes::Branch && w[14:13] == 2'b01)) begin
            e.opClass = RvTypes::Unknown;
        end
        case (e.opClass)
            RvTypes::AluImm, RvTypes::Load, RvTypes::Jalr, RvTypes::System:
                e.imm = {{20{w[31]}}, w[31:20]};
            RvTypes::Store: e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            RvTypes::Branch: e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            RvTypes::Jal: e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            RvTypes::Lui, RvTypes::Auipc: e.imm = {w[31:12], 12'b0};
            default: e.imm = '0;
        endcase
        e.writesRd = !(e.opClass == RvTypes::Store || e.opClass == RvTypes::Branch ||
                       e.opClass == RvTypes::Unknown);
        // A misaligned PC outranks an illegal word.
        if (pc[1:0] != 2'b00) begin
            e.trap.valid = 1'b1;
            e.trap.cause = RvTypes::InsnMisaligned;
            e.trap.value = pc;
        end
        else if (e.opClass == RvTypes::Unknown) begin
            e.trap.valid = 1'b1;
            e.trap.cause = RvTypes::IllegalInsn;
            e.trap.value = w;
        end
        return e;
    endfunction

    task automatic checkOpClass(input string name, input RvTypes::OpClass exp,
                                input RvTypes::OpClass act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkWord(input string name, input logic [`RV_XLEN-1:0] exp,
                             input logic [`RV_XLEN-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkRegAddr(input string name, input logic [`RV_REG_ADDR_WIDTH-1:0] exp,
                                input logic [`RV_REG_ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkOpId(input string name, input logic [`RV_OPID_WIDTH-1:0] exp,
                             input logic [`RV_OPID_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkTrap(input string name, input RvTypes::TrapInfo exp,
                             input RvTypes::TrapInfo act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            abortRun();
        end
    endtask

    // Inputs change shortly after the rising edge.
    task automatic driveCycle(input logic active);
        logic [31:0] pc;
        logic [31:0] misalign;
        @(posedge clk);
        #1;
        if (!active) begin
            inValid = 1'b0;
            outReady = 1'b1;
            flush = 1'b0;
        end
        else begin
            if (!inHeld) begin
                pc = takeBits(32) & 32'hffff_fffc;
                if (takeBits(4) == 0) begin
                    misalign = takeBits(2);
                    pc[1:0] = misalign[1:0];
                end
                inPc = pc;
                inInsn = randomWord();
                inValid = (takeBits(2) != 0);
            end
            outReady = (takeBits(2) != 0);
            flush = (takeBits(6) == 0);
        end
    endtask

    // Handshakes are judged at the falling edge, where all signals are settled.
    task automatic observeCycle();
        ExpectedOp expected;
        RvTypes::TrapInfo actualTrap;
        @(negedge clk);
        if (outValid && outReady) begin
            if (expectedOps.size() == 0) begin
                $display("An op was handed off while none was expected");
                abortRun();
            end
            else begin
                expected = expectedOps.pop_front();
                actualTrap.valid = outTrapValid;
                actualTrap.cause = outTrapCause;
                actualTrap.value = outTrapValue;
                checkWord("outPc", expected.pc, outPc);
                checkWord("outInsn", expected.insn, outInsn);
                checkOpClass("outOpClass", expected.opClass, outOpClass);
                checkWord("outImm", expected.imm, outImm);
                checkFlag("outWritesRd", expected.writesRd, outWritesRd);
                checkRegAddr("outRs1", expected.rs1, outRs1);
                checkRegAddr("outRs2", expected.rs2, outRs2);
                checkRegAddr("outRd", expected.rd, outRd);
                checkOpId("outOpId", handoffCount, outOpId);
                checkTrap("outTrap", expected.trap, actualTrap);
                handoffCount = handoffCount + 1'b1;
            end
        end
        if (flush) begin
            expectedOps.delete();
        end
        if (inValid && inReady) begin
            expectedOps.push_back(modelDecode(inPc, inInsn));
            takenCount = takenCount + 1;
        end
        inHeld = inValid && !inReady;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inValid = 1'b0;
        inPc = '0;
        inInsn = '0;
        outReady = 1'b0;
        flush = 1'b0;
        lfsrState = 32'h3c7e1a3c;
        inHeld = 1'b0;
        takenCount = 0;
        cycleCount = 0;
        handoffCount = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkFlag("outValid", 1'b0, outValid);
        checkTrap("outTrap", '0, {outTrapValid, outTrapCause, outTrapValue});
        checkFlag("inReady", 1'b1, inReady);
        while (takenCount < txnTarget) begin
            driveCycle(1'b1);
            observeCycle();
        end
        // Without back-pressure both stages empty within a few cycles.
        repeat (4) begin
            driveCycle(1'b0);
            observeCycle();
        end
        if (expectedOps.size() != 0) begin
            $display("Taken ops were never handed off after the drain");
            abortRun();
        end
        else begin
            $display("Simulation PASSED");
            $finish;
        end
    end
endmodule

//--- all.f
+incdir+hdl
hdl/RvTypes.sv
hdl/StageIF.sv
hdl/FetchStage.sv
hdl/DecodeStage.sv
hdl/PipelineController.sv
hdl/DecodeFrontEnd.sv
dv/DecodeFrontEnd_assert.sv
dv/tb_DecodeFrontEnd.sv

//--- run.sh
#!/bin/sh
# Build and run the decode front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_DecodeFrontEnd \
    -f all.f > sim.log 2>&1 &&
    ./obj_dir/Vtb_DecodeFrontEnd >> sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
